// ==== files.f ====
fm_pkg.sv
fm_bus_fsm.sv
fm_prescaler.sv
fm_mmr.sv
fm_timers.sv
fm_chan_regs.sv
fm_regif_top.sv
tb_fm_regif.sv

// ==== fm_bus_fsm.sv ====
// wishbone classic slave, single-cycle ack, no wait states or errors; host must poll busy
`timescale 1ns/100ps

module fm_bus_fsm import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  byte_t      dat_i,
    input  byte_t      status,
    output logic       ack,
    output byte_t      dat_o,
    output logic       wr_pulse,
    output logic [1:0] wr_addr,
    output byte_t      wr_data
);

    bus_state_t state;

    assign ack = (state == BUS_ACK);   // one cycle, every cycle passes through ACK

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= BUS_IDLE;
            wr_pulse <= 1'b0;
            dat_o    <= '0;
        end else begin
            wr_pulse <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (cyc && stb) begin
                        state <= BUS_ACK;
                        if (we) begin
                            wr_pulse <= 1'b1;
                        end else begin
                            dat_o <= status;   // status sampled on the accepted edge
                        end
                    end
                end
                BUS_ACK: begin
                    state <= BUS_IDLE;   // back to idle, next strobe seen next cycle
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // write payload, qualified by wr_pulse downstream
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && cyc && stb && we) begin
            wr_addr <= adr;
            wr_data <= dat_i;
        end
    end

endmodule

// ==== fm_chan_regs.sv ====
// six-channel register file with one shared freq-high latch; ch_sel 6 and 7 read as zero
`timescale 1ns/100ps

module fm_chan_regs import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       up_fnum,
    input  logic       up_latch,
    input  logic       up_alg,
    input  logic       up_kon,
    input  chan_t      up_ch,
    input  byte_t      up_data,
    input  chan_t      ch_sel,
    output fnum_t      fnum,
    output block_t     block,
    output fb_t        fb,
    output alg_t       alg,
    output slot_mask_t kon_mask
);

    logic [5:0] latch_fnum;   // block in 5:3, fnum high in 2:0

    fnum_t      fnum_r  [NUM_CH];
    block_t     block_r [NUM_CH];
    fb_t        fb_r    [NUM_CH];
    alg_t       alg_r   [NUM_CH];
    slot_mask_t kon_r   [NUM_CH];

    always_ff @(posedge clk) begin
        if (rst) begin
            latch_fnum <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                fnum_r[i]  <= '0;
                block_r[i] <= '0;
                fb_r[i]    <= '0;
                alg_r[i]   <= '0;
                kon_r[i]   <= '0;
            end
        end else begin
            if (up_latch) begin
                latch_fnum <= up_data[5:0];   // shared by all channels
            end
            if (up_ch < chan_t'(NUM_CH)) begin
                if (up_fnum) begin
                    fnum_r[up_ch]  <= {latch_fnum[2:0], up_data};
                    block_r[up_ch] <= latch_fnum[5:3];
                end
                if (up_alg) begin
                    fb_r[up_ch]  <= up_data[5:3];
                    alg_r[up_ch] <= up_data[2:0];
                end
                if (up_kon) begin
                    kon_r[up_ch] <= up_data[7:4];   // one bit per slot
                end
            end
        end
    end

    // readout port
    always_comb begin
        if (ch_sel < chan_t'(NUM_CH)) begin
            fnum     = fnum_r[ch_sel];
            block    = block_r[ch_sel];
            fb       = fb_r[ch_sel];
            alg      = alg_r[ch_sel];
            kon_mask = kon_r[ch_sel];
        end else begin
            fnum     = '0;
            block    = '0;
            fb       = '0;
            alg      = '0;
            kon_mask = '0;
        end
    end

endmodule

// ==== fm_mmr.sv ====
// register decoder; global registers decoded in either part, operator regs and ch3 mode ignored
`timescale 1ns/100ps

module fm_mmr import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_pulse,
    input  logic [1:0] wr_addr,
    input  byte_t      wr_data,
    output div_sel_t   div_sel,
    output logic       busy_start,
    output timer_a_t   value_a,
    output timer_b_t   value_b,
    output logic       load_a,
    output logic       load_b,
    output logic       irq_en_a,
    output logic       irq_en_b,
    output logic       clr_a,
    output logic       clr_b,
    output logic       up_fnum,
    output logic       up_latch,
    output logic       up_alg,
    output logic       up_kon,
    output chan_t      up_ch,
    output byte_t      up_data
);

    reg_addr_t sel_reg;
    logic      part;       // 0 for channels 0-2, 1 for 3-5
    logic      data_wr;
    logic      chan_slot;  // low bits 3 is not a channel
    chan_t     reg_ch;
    chan_t     kon_ch;
    logic      kon_valid;

    assign data_wr   = wr_pulse && wr_addr[0];
    assign chan_slot = (sel_reg[1:0] != 2'b11);
    assign reg_ch    = chan_t'(sel_reg[1:0]) + (part ? chan_t'(CH_PER_PART) : chan_t'(0));

    // key-on channel code: 0-2 part 0, 4-6 part 1
    assign kon_valid = (wr_data[1:0] != 2'b11);
    assign kon_ch    = chan_t'(wr_data[1:0])
                     + (wr_data[2] ? chan_t'(CH_PER_PART) : chan_t'(0));

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg    <= '0;
            part       <= 1'b0;
            div_sel    <= DIV_RESET;
            busy_start <= 1'b0;
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            up_fnum    <= 1'b0;
            up_latch   <= 1'b0;
            up_alg     <= 1'b0;
            up_kon     <= 1'b0;
        end else begin
            // one-cycle pulses
            busy_start <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            up_fnum    <= 1'b0;
            up_latch   <= 1'b0;
            up_alg     <= 1'b0;
            up_kon     <= 1'b0;
            if (wr_pulse && !wr_addr[0]) begin
                sel_reg <= wr_data;       // address port
                part    <= wr_addr[1];
            end else if (data_wr) begin
                busy_start <= 1'b1;
                case (sel_reg)
                    REG_CLKA1:  value_a[9:2] <= wr_data;
                    REG_CLKA2:  value_a[1:0] <= wr_data[1:0];
                    REG_CLKB:   value_b      <= wr_data;
                    REG_TIMER: begin
                        {clr_b, clr_a, irq_en_b, irq_en_a, load_b, load_a} <= wr_data[5:0];
                    end
                    REG_KON:    up_kon <= kon_valid;
                    REG_CLK_N6: div_sel[1] <= 1'b1;
                    REG_CLK_N3: div_sel[0] <= 1'b1;
                    REG_CLK_N2: div_sel    <= 2'b00;
                    default: ;
                endcase
                if (chan_slot) begin
                    up_fnum  <= (sel_reg[7:2] == REG_FNUM_LO[7:2]);
                    up_latch <= (sel_reg[7:2] == REG_FNUM_HI[7:2]);
                    up_alg   <= (sel_reg[7:2] == REG_FB_ALG[7:2]);
                end
            end
        end
    end

    // channel payload, only meaningful alongside a strobe
    always_ff @(posedge clk) begin
        if (data_wr) begin
            up_data <= wr_data;
            up_ch   <= (sel_reg == REG_KON) ? kon_ch : reg_ch;
        end
    end

endmodule

// ==== fm_pkg.sv ====
// shared widths, register map and prescaler constants; only part 0/1 channel and global regs exist
package fm_pkg;

    typedef logic [7:0]  byte_t;       // bus data and register byte
    typedef logic [7:0]  reg_addr_t;   // selected register number
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [2:0]  chan_t;       // 0 to 5 valid
    typedef logic [2:0]  alg_t;
    typedef logic [2:0]  fb_t;
    typedef logic [3:0]  slot_mask_t;
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;
    typedef logic [1:0]  div_sel_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_t;

    // global registers
    localparam reg_addr_t REG_CLKA1  = 8'h24;
    localparam reg_addr_t REG_CLKA2  = 8'h25;
    localparam reg_addr_t REG_CLKB   = 8'h26;
    localparam reg_addr_t REG_TIMER  = 8'h27;
    localparam reg_addr_t REG_KON    = 8'h28;
    localparam reg_addr_t REG_CLK_N6 = 8'h2D;
    localparam reg_addr_t REG_CLK_N3 = 8'h2E;
    localparam reg_addr_t REG_CLK_N2 = 8'h2F;

    // channel register bases, low two bits pick the channel within a part
    localparam reg_addr_t REG_FNUM_LO = 8'hA0;
    localparam reg_addr_t REG_FNUM_HI = 8'hA4;
    localparam reg_addr_t REG_FB_ALG  = 8'hB0;

    localparam int NUM_CH      = 6;
    localparam int CH_PER_PART = 3;
    localparam int BUSY_TICKS  = 32;
    localparam int TIMER_B_PRE = 16;

    // prescaler
    localparam div_sel_t   DIV_RESET   = 2'b11;
    localparam logic [2:0] DIV_RATIO_2 = 3'd2;
    localparam logic [2:0] DIV_RATIO_3 = 3'd3;
    localparam logic [2:0] DIV_RATIO_6 = 3'd6;

endpackage

// ==== fm_prescaler.sv ====
// tick every 2, 3 or 6 cen pulses; busy counts ticks so it stalls if cen stops
`timescale 1ns/100ps

module fm_prescaler import fm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    input  logic     busy_start,
    output logic     tick,
    output logic     busy
);

    logic [2:0] ratio;
    logic [2:0] div_cnt;
    logic [4:0] busy_cnt;

    always_comb begin
        case (div_sel)
            2'b00:   ratio = DIV_RATIO_2;
            2'b01:   ratio = DIV_RATIO_3;
            default: ratio = DIV_RATIO_6;   // 10 and 11 both divide by 6
        endcase
    end

    // divide counter runs down over cen, reload picks up a new ratio
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (cen) begin
                if (div_cnt == '0) begin
                    tick    <= 1'b1;
                    div_cnt <= ratio - 3'd1;
                end else begin
                    div_cnt <= div_cnt - 3'd1;
                end
            end
        end
    end

    // busy held for BUSY_TICKS ticks after the last data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (busy_start) begin
            busy     <= 1'b1;
            busy_cnt <= '0;   // restart on every write
        end else if (busy && tick) begin
            if (busy_cnt == 5'(BUSY_TICKS - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 5'd1;
        end
    end

endmodule

// ==== fm_regif_top.sv ====
// register interface top; channel state read via ch_sel, not over the bus
`timescale 1ns/100ps

module fm_regif_top import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  byte_t      dat_i,
    input  chan_t      ch_sel,
    output logic       ack,
    output byte_t      dat_o,
    output logic       irq,
    output fnum_t      fnum,
    output block_t     block,
    output fb_t        fb,
    output alg_t       alg,
    output slot_mask_t kon_mask
);

    byte_t      status;
    logic       wr_pulse;
    logic [1:0] wr_addr;
    byte_t      wr_data;
    div_sel_t   div_sel;
    logic       busy_start, tick, busy;
    timer_a_t   value_a;
    timer_b_t   value_b;
    logic       load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b;
    logic       flag_a, flag_b;
    logic       up_fnum, up_latch, up_alg, up_kon;
    chan_t      up_ch;
    byte_t      up_data;

    assign status = {busy, 5'b0, flag_b, flag_a};
    assign irq    = flag_a | flag_b;

    fm_bus_fsm u_bus (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_i(dat_i), .status(status), .ack(ack), .dat_o(dat_o),
        .wr_pulse(wr_pulse), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    fm_prescaler u_pre (
        .clk(clk), .rst(rst), .cen(cen), .div_sel(div_sel),
        .busy_start(busy_start), .tick(tick), .busy(busy)
    );

    fm_mmr u_mmr (
        .clk(clk), .rst(rst), .wr_pulse(wr_pulse), .wr_addr(wr_addr), .wr_data(wr_data),
        .div_sel(div_sel), .busy_start(busy_start), .value_a(value_a), .value_b(value_b),
        .load_a(load_a), .load_b(load_b), .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_a(clr_a), .clr_b(clr_b), .up_fnum(up_fnum), .up_latch(up_latch),
        .up_alg(up_alg), .up_kon(up_kon), .up_ch(up_ch), .up_data(up_data)
    );

    fm_timers u_tmr (
        .clk(clk), .rst(rst), .tick(tick), .value_a(value_a), .value_b(value_b),
        .load_a(load_a), .load_b(load_b), .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_a(clr_a), .clr_b(clr_b), .flag_a(flag_a), .flag_b(flag_b)
    );

    fm_chan_regs u_ch (
        .clk(clk), .rst(rst), .up_fnum(up_fnum), .up_latch(up_latch), .up_alg(up_alg),
        .up_kon(up_kon), .up_ch(up_ch), .up_data(up_data), .ch_sel(ch_sel),
        .fnum(fnum), .block(block), .fb(fb), .alg(alg), .kon_mask(kon_mask)
    );

endmodule

// ==== fm_timers.sv ====
// timer a steps every tick, timer b every TIMER_B_PRE ticks; flags held until cleared
`timescale 1ns/100ps

module fm_timers import fm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     tick,
    input  timer_a_t value_a,
    input  timer_b_t value_b,
    input  logic     load_a,
    input  logic     load_b,
    input  logic     irq_en_a,
    input  logic     irq_en_b,
    input  logic     clr_a,
    input  logic     clr_b,
    output logic     flag_a,
    output logic     flag_b
);

    timer_a_t cnt_a;
    timer_b_t cnt_b;
    logic [$clog2(TIMER_B_PRE)-1:0] pre_b;
    logic ovf_a;
    logic ovf_b;
    logic step_b;

    assign step_b = tick && (pre_b == '1);
    assign ovf_a  = load_a && tick && (cnt_a == '1);
    assign ovf_b  = load_b && step_b && (cnt_b == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
            cnt_b <= '0;
            pre_b <= '0;
        end else begin
            if (!load_a) begin
                cnt_a <= value_a;           // stopped, preset from value
            end else if (tick) begin
                cnt_a <= ovf_a ? value_a : cnt_a + 1'b1;
            end
            if (!load_b) begin
                cnt_b <= value_b;
                pre_b <= '0;                // b prescale restarts with the timer
            end else if (tick) begin
                pre_b <= pre_b + 1'b1;
                if (step_b) begin
                    cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
                end
            end
        end
    end

    // an overflow on the same cycle as a clear wins
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && irq_en_a) begin
                flag_a <= 1'b1;
            end else if (clr_a) begin
                flag_a <= 1'b0;
            end
            if (ovf_b && irq_en_b) begin
                flag_b <= 1'b1;
            end else if (clr_b) begin
                flag_b <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_fm_regif.sv ====
// directed testbench; cen held high and tick phase unknown, so timed spans are checked as windows
`timescale 1ns/100ps

module tb_fm_regif import fm_pkg::*; ();

    localparam int MAX_CYCLES = 4000;   // all tests together need well under 2000 cycles
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 120;    // one status read every 3 cycles

    logic       clk, rst, cen, cyc, stb, we, ack, irq;
    logic [1:0] adr;
    byte_t      dat_i, dat_o;
    chan_t      ch_sel;
    fnum_t      fnum;
    block_t     block;
    fb_t        fb;
    alg_t       alg;
    slot_mask_t kon_mask;

    integer seed = 32'h8d82288c;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int last_ack = 0;   // cycle count at the latest ack

    // expected channel state, built from the written bytes
    fnum_t      exp_fnum  [NUM_CH];
    block_t     exp_block [NUM_CH];
    fb_t        exp_fb    [NUM_CH];
    alg_t       exp_alg   [NUM_CH];
    slot_mask_t exp_kon   [NUM_CH];

    fm_regif_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    // span of a given number of ticks at divide n, first tick 1..n cycles in
    task automatic check_tick_window(input string what, input int elapsed, input int ticks,
                                     input int n, input int lead, input int early,
                                     input int late);
        int lo;
        int hi;
        lo = lead + (ticks - 1) * n + 1 + early;
        hi = lead + ticks * n + late;
        checks++;
        if (elapsed < lo || elapsed > hi) begin
            $display("%s took %0d cycles, expected %0d to %0d", what, elapsed, lo, hi);
            errors++;
        end
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge clk);
        while (!ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            last_ack = cycles;
        end else begin
            $display("bus cycle got no ack within %0d cycles", ACK_LIMIT);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [1:0] a, input byte_t d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_i <= d;
        wait_ack();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a, output byte_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_ack();
        d = dat_o;   // sampled at the negedge of the ack cycle
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // address port, then data port of the same part
    task automatic reg_write(input logic part, input reg_addr_t ra, input byte_t d);
        bus_write({part, 1'b0}, ra);
        bus_write({part, 1'b1}, d);
    endtask

    // walks all channels starting at first, one per cycle
    task automatic check_channels(input int first);
        int c;
        for (int i = 0; i < NUM_CH; i++) begin
            c = (first + i) % NUM_CH;
            @(posedge clk);
            ch_sel <= chan_t'(c);
            @(negedge clk);
            check_value($sformatf("fnum[%0d]", c), fnum, exp_fnum[c]);
            check_value($sformatf("block[%0d]", c), block, exp_block[c]);
            check_value($sformatf("fb[%0d]", c), fb, exp_fb[c]);
            check_value($sformatf("alg[%0d]", c), alg, exp_alg[c]);
            check_value($sformatf("kon_mask[%0d]", c), kon_mask, exp_kon[c]);
        end
    endtask

    // reads status until busy drops, elapsed counts from start to the idle read
    task automatic poll_busy(input int start, output int elapsed);
        byte_t st;
        int n;
        n = 0;
        st = 8'h80;
        while (st[7] && n < POLL_LIMIT) begin
            bus_read(2'b00, st);
            n++;
        end
        elapsed = last_ack - start;
        if (st[7]) begin
            $display("busy still set after %0d status reads", n);
            errors++;
        end
    endtask

    task automatic wait_irq(input int limit, output int elapsed);
        int start;
        start = last_ack;
        @(negedge clk);
        while (!irq && cycles - start < limit) begin
            @(negedge clk);
        end
        elapsed = cycles - start;
        if (!irq) begin
            $display("irq did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s: done, %0d errors", name, errors - err0);
    endtask

    task automatic reset_and_bus();
        byte_t st;
        int err0;
        err0 = errors;
        @(negedge clk);
        check_value("dat_o", dat_o, 8'h00);
        check_value("irq", irq, 1'b0);
        bus_read(2'b00, st);
        check_value("status", st, 8'h00);
        @(negedge clk);
        check_value("ack", ack, 1'b0);   // ack high for a single cycle
        bus_read(2'b10, st);
        check_value("status", st, 8'h00);
        check_channels(0);
        report_test("reset and bus", err0);
    endtask

    task automatic chan_freq_alg();
        byte_t lat, lo, fa, lat2;
        logic part;
        reg_addr_t low;
        int err0;
        err0 = errors;
        for (int c = 0; c < NUM_CH; c++) begin
            part = (c >= CH_PER_PART);
            low  = reg_addr_t'(c % CH_PER_PART);
            lat  = byte_t'($random(seed));
            lo   = byte_t'($random(seed));
            fa   = byte_t'($random(seed));
            lat2 = byte_t'($random(seed));
            reg_write(part, REG_FNUM_HI + low, lat);
            reg_write(part, REG_FNUM_LO + low, lo);
            reg_write(part, REG_FB_ALG + low, fa);
            exp_fnum[c]  = {lat[2:0], lo};
            exp_block[c] = lat[5:3];
            exp_fb[c]    = fa[5:3];
            exp_alg[c]   = fa[2:0];
            check_channels(c);   // channel c seen two cycles after the ack
            reg_write(part, REG_FNUM_HI + low, lat2);   // stays in the latch only
            check_channels(c);
        end
        report_test("channel frequency and algorithm", err0);
    endtask

    task automatic key_on_masks();
        int idx;
        int code;
        slot_mask_t mask;
        int err0;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            idx  = {$random(seed)} % NUM_CH;
            mask = slot_mask_t'($random(seed));
            code = (idx < CH_PER_PART) ? idx : idx + 1;   // part 1 uses codes 4 to 6
            reg_write(1'b0, REG_KON, {mask, 1'b0, code[2:0]});
            exp_kon[idx] = mask;
            check_channels(idx);
        end
        reg_write(1'b0, REG_KON, 8'hF3);   // code 3 names no channel
        check_channels(0);
        report_test("key-on", err0);
    endtask

    task automatic busy_timing();
        byte_t st;
        int start;
        int elapsed;
        int err0;
        err0 = errors;
        poll_busy(last_ack, elapsed);   // let earlier writes run out
        bus_write(2'b00, 8'h30);
        bus_read(2'b00, st);
        check_value("status", st, 8'h00);
        bus_write(2'b10, 8'h30);
        bus_read(2'b00, st);
        check_value("status", st, 8'h00);
        bus_write(2'b01, 8'h00);   // data write to an unused register
        start = last_ack;
        bus_read(2'b00, st);
        check_value("status", st, 8'h80);
        poll_busy(start, elapsed);
        check_tick_window("busy at divide 6", elapsed, BUSY_TICKS, 6, 2, 1, 3);
        reg_write(1'b0, REG_CLK_N2, 8'h00);
        poll_busy(last_ack, elapsed);
        bus_write(2'b01, 8'h00);   // N2 still selected
        start = last_ack;
        bus_read(2'b00, st);
        check_value("status", st, 8'h80);
        poll_busy(start, elapsed);
        check_tick_window("busy at divide 2", elapsed, BUSY_TICKS, 2, 2, 1, 3);
        report_test("busy", err0);
    endtask

    // runs at divide 2, left there by the busy test
    task automatic timer_flags();
        byte_t st;
        int elapsed;
        logic seen;
        int err0;
        err0 = errors;
        reg_write(1'b0, REG_CLKA1, 8'hFF);   // 1020 upper bits
        reg_write(1'b0, REG_CLKA2, 8'h00);
        @(negedge clk);
        check_value("irq", irq, 1'b0);
        reg_write(1'b0, REG_TIMER, 8'h05);   // load a, enable a
        wait_irq(40, elapsed);
        check_tick_window("flag a", elapsed, 4, 2, 1, 0, 0);
        bus_read(2'b00, st);
        check_value("status flags", st & 8'h03, 8'h01);
        reg_write(1'b0, REG_TIMER, 8'h10);   // clear a, timer stopped
        @(posedge clk);
        @(negedge clk);
        check_value("irq", irq, 1'b0);
        reg_write(1'b0, REG_CLKB, 8'hFE);
        reg_write(1'b0, REG_TIMER, 8'h0A);   // load b, enable b
        wait_irq(120, elapsed);
        check_tick_window("flag b", elapsed, 2 * TIMER_B_PRE, 2, 1, 0, 0);
        bus_read(2'b00, st);
        check_value("status flags", st & 8'h03, 8'h02);
        reg_write(1'b0, REG_TIMER, 8'h20);
        @(posedge clk);
        @(negedge clk);
        check_value("irq", irq, 1'b0);
        reg_write(1'b0, REG_TIMER, 8'h03);   // both running, no enables
        seen = 1'b0;
        repeat (150) begin
            @(negedge clk);
            seen = seen | irq;
        end
        check_value("irq", seen, 1'b0);
        bus_read(2'b00, st);
        check_value("status flags", st & 8'h03, 8'h00);
        reg_write(1'b0, REG_TIMER, 8'h00);
        report_test("timers", err0);
    endtask

    initial begin
        rst    = 1'b1;
        cen    = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 2'b00;
        dat_i  = 8'h00;
        ch_sel = 3'd0;
        for (int c = 0; c < NUM_CH; c++) begin
            exp_fnum[c]  = '0;
            exp_block[c] = '0;
            exp_fb[c]    = '0;
            exp_alg[c]   = '0;
            exp_kon[c]   = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_and_bus();
        chan_freq_alg();
        key_on_masks();
        busy_timing();
        timer_flags();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
